// File: verilog/lsq_settings.svh
/*
 * Size settings for the load/store queue store-operand path.
 * Queue rows, register file sizes and the register data width.
 */

`ifndef LSQ_SETTINGS_SVH
`define LSQ_SETTINGS_SVH

// ====================
// Queue geometry
// ====================

// Number of queue rows with two entries (column 0 and column 1) in each row
`define LSQ_ROWS 8

// ====================
// Register files
// ====================

// Physical registers held in the register file
`define PREGS 64
// Architectural registers named by the program
`define AREGS 32
// Width of one register data word
`define DATA_W 32

`endif

// File: verilog/lsq_pkg.sv
/*
 * Shared types for the load/store queue store-operand path.
 * Register numbers, checkpoint index, data word, queue index and entry.
 */

`default_nettype none

`include "lsq_settings.svh"

package lsq_pkg;

	// ====================
	// Register and data types
	// ====================

	// Architectural register number of 5 bits for 32 registers
	typedef logic [$clog2(`AREGS)-1:0] aregno_t;

	// Physical register number of 6 bits for 64 registers
	typedef logic [$clog2(`PREGS)-1:0] pregno_t;

	// Checkpoint index that is only carried through to retirement here
	typedef logic [4:0] checkpt_ndx_t;

	// One register data word
	typedef logic [`DATA_W-1:0] data_t;

	// ====================
	// Queue types
	// ====================

	// Locates one entry by its row and the column inside that row
	// Column 0 comes before column 1, then the next row follows
	typedef struct packed {
		logic [$clog2(`LSQ_ROWS)-1:0] row;
		logic col;
	} lsq_ndx_t;

	// One queue entry
	// The dv flag is set once the store data has been captured
	typedef struct packed {
		logic v;
		logic store;
		logic dv;
		aregno_t aRc;
		pregno_t pRc;
		checkpt_ndx_t cndx;
		data_t data;
	} lsq_entry_t;

endpackage

`default_nettype wire

// File: verilog/lsq_store.sv
/*
 * Queue entry storage with head and tail pointers and an entry count.
 * Enqueue at the tail, store data capture, in-order retirement at the head.
 */

`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_store (
	input  logic clk,
	input  logic rst,
	input  logic enq,
	input  logic enq_store,
	input  lsq_pkg::aregno_t enq_areg,
	input  lsq_pkg::pregno_t enq_preg,
	input  lsq_pkg::checkpt_ndx_t enq_cndx,
	input  logic cap_wr,
	input  lsq_pkg::lsq_ndx_t cap_ndx,
	input  lsq_pkg::data_t cap_data,
	output lsq_pkg::lsq_entry_t [1:0] lsq [0:`LSQ_ROWS-1],
	output lsq_pkg::lsq_ndx_t lsq_head,
	output logic full,
	output logic ret_v,
	output logic ret_store,
	output lsq_pkg::aregno_t ret_areg,
	output lsq_pkg::pregno_t ret_preg,
	output lsq_pkg::checkpt_ndx_t ret_cndx,
	output lsq_pkg::data_t ret_data
);

	localparam int ENTRIES = 2 * `LSQ_ROWS;
	localparam int CNT_W = $clog2(ENTRIES + 1);
	localparam int LAST_ROW = `LSQ_ROWS - 1;

	lsq_pkg::lsq_ndx_t tail;
	logic [CNT_W-1:0] count;
	lsq_pkg::lsq_entry_t head_ent;
	logic retire;

	// Steps an index to the next entry with column 0 first and a wrap after the last row
	function automatic lsq_pkg::lsq_ndx_t next_ndx(input lsq_pkg::lsq_ndx_t n);
		lsq_pkg::lsq_ndx_t r;
		r = n;
		if (n.col == 1'b0) begin
			r.col = 1'b1;
		end
		else begin
			r.col = 1'b0;
			if (int'(n.row) == LAST_ROW)
				r.row = '0;
			else
				r.row = n.row + 1'b1;
		end
		return r;
	endfunction

	// ====================
	// Head and retire test
	// ====================

	assign head_ent = lsq[lsq_head.row][lsq_head.col];

	// A load may leave as soon as it is at the head while a store waits for its data
	assign retire = head_ent.v && (!head_ent.store || head_ent.dv);

	// Full is decoded from the entry count
	assign full = (count == CNT_W'(ENTRIES));

	// ====================
	// Pointers and entries
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			lsq_head <= '0;
			tail <= '0;
			count <= '0;
			ret_v <= 1'b0;
			for (int r = 0; r < `LSQ_ROWS; r++) begin
				lsq[r][0].v <= 1'b0;
				lsq[r][1].v <= 1'b0;
			end
		end
		else begin
			// Retirement pulses the ret outputs for one cycle only
			ret_v <= retire;
			if (retire) begin
				ret_store <= head_ent.store;
				ret_areg <= head_ent.aRc;
				ret_preg <= head_ent.pRc;
				ret_cndx <= head_ent.cndx;
				// Loads carry no data out of this path
				ret_data <= head_ent.store ? head_ent.data : '0;
				lsq[lsq_head.row][lsq_head.col].v <= 1'b0;
				lsq_head <= next_ndx(lsq_head);
			end

			// Capture writes arrive already checked against the target entry
			if (cap_wr) begin
				lsq[cap_ndx.row][cap_ndx.col].data <= cap_data;
				lsq[cap_ndx.row][cap_ndx.col].dv <= 1'b1;
			end

			// New entries go in at the tail with no data yet
			if (enq) begin
				lsq[tail.row][tail.col].v <= 1'b1;
				lsq[tail.row][tail.col].store <= enq_store;
				lsq[tail.row][tail.col].dv <= 1'b0;
				lsq[tail.row][tail.col].aRc <= enq_areg;
				lsq[tail.row][tail.col].pRc <= enq_preg;
				lsq[tail.row][tail.col].cndx <= enq_cndx;
				tail <= next_ndx(tail);
			end

			// Count follows enqueues and retirements, which may happen together
			case ({enq, retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ====================
	// Assertions
	// ====================

	// The source of enqueues must watch full since a new entry has nowhere to go
	assert property (@(posedge clk) disable iff (rst) enq |-> !full)
		else $error("enqueue while the queue is full");

	// The capture stage only writes into an entry that is still in use
	assert property (@(posedge clk) disable iff (rst)
		cap_wr |-> lsq[cap_ndx.row][cap_ndx.col].v)
		else $error("capture write to an invalid entry");

	// Head and tail meet exactly when the queue is empty or full
	assert property (@(posedge clk) disable iff (rst)
		(lsq_head == tail) == (count == '0 || full))
		else $error("head and tail pointers out of step with the entry count");

endmodule

`default_nettype wire

// File: verilog/lsq_reg_read_req.sv
/*
 * Read-request stage for store operands.
 * Samples the head entry and issues a register read for stores.
 */

`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_reg_read_req (
	input  logic clk,
	input  logic rst,
	input  lsq_pkg::lsq_ndx_t lsq_head,
	input  lsq_pkg::lsq_entry_t [1:0] lsq [0:`LSQ_ROWS-1],
	output lsq_pkg::aregno_t aReg,
	output lsq_pkg::pregno_t rd_preg,
	output lsq_pkg::checkpt_ndx_t cndx,
	output lsq_pkg::lsq_ndx_t id,
	output lsq_pkg::lsq_ndx_t id1,
	output logic rd_v
);

	lsq_pkg::lsq_entry_t head_ent;

	// The head entry as seen this cycle
	assign head_ent = lsq[lsq_head.row][lsq_head.col];

	// ====================
	// Request register
	// ====================

	// The read is issued every cycle the head is valid, so reads can overlap
	// Stale replies are rejected later by the capture stage
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_v <= 1'b0;
		end
		else begin
			// Only stores need their data register read
			rd_v <= head_ent.v && head_ent.store;
		end
	end

	// Fields of the head are held while the head is empty
	always_ff @(posedge clk) begin
		if (head_ent.v) begin
			aReg <= head_ent.aRc;
			rd_preg <= head_ent.pRc;
			cndx <= head_ent.cndx;
			// The index rides with the read as its tag
			id <= lsq_head;
			// Delayed copy of the tag that lines up with the register reply
			id1 <= id;
		end
	end

endmodule

`default_nettype wire

// File: verilog/prf.sv
/*
 * Physical register file with one write port and one registered read port.
 * Reads carry a queue index tag through to the reply.
 */

`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module prf (
	input  logic clk,
	input  logic rst,
	input  logic wr,
	input  lsq_pkg::pregno_t wr_preg,
	input  lsq_pkg::data_t wr_data,
	input  logic rd_v,
	input  lsq_pkg::pregno_t rd_preg,
	input  lsq_pkg::lsq_ndx_t rd_tag,
	output logic rsp_v,
	output lsq_pkg::pregno_t rsp_preg,
	output lsq_pkg::lsq_ndx_t rsp_tag,
	output lsq_pkg::data_t rsp_data
);

	lsq_pkg::data_t regs [0:`PREGS-1];

	// ====================
	// Register array
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `PREGS; i++)
				regs[i] <= '0;
		end
		else if (wr) begin
			regs[wr_preg] <= wr_data;
		end
	end

	// ====================
	// Read reply
	// ====================

	always_ff @(posedge clk) begin
		if (rst)
			rsp_v <= 1'b0;
		else
			rsp_v <= rd_v;
	end

	// A write to the register being read on the same edge is passed straight through
	always_ff @(posedge clk) begin
		rsp_preg <= rd_preg;
		rsp_tag <= rd_tag;
		rsp_data <= (wr && wr_preg == rd_preg) ? wr_data : regs[rd_preg];
	end

endmodule

`default_nettype wire

// File: verilog/lsq_data_capture.sv
/*
 * Store data capture.
 * Checks a tagged register reply against its queue entry and builds the write.
 */

`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_data_capture (
	input  logic rsp_v,
	input  lsq_pkg::pregno_t rsp_preg,
	input  lsq_pkg::lsq_ndx_t rsp_tag,
	input  lsq_pkg::data_t rsp_data,
	input  lsq_pkg::lsq_entry_t [1:0] lsq [0:`LSQ_ROWS-1],
	output logic cap_wr,
	output lsq_pkg::lsq_ndx_t cap_ndx,
	output lsq_pkg::data_t cap_data
);

	lsq_pkg::lsq_entry_t tgt;
	logic tgt_match;

	// Entry named by the reply tag
	assign tgt = lsq[rsp_tag.row][rsp_tag.col];

	// ====================
	// Acceptance rule
	// ====================

	// The slot must still hold a store waiting on this very register
	// Replies to a retired or reused slot fail one of these tests and are dropped
	// Repeated replies are dropped as well once dv is set
	assign tgt_match = tgt.v && tgt.store && !tgt.dv && (tgt.pRc == rsp_preg);

	assign cap_wr = rsp_v && tgt_match;
	assign cap_ndx = rsp_tag;
	assign cap_data = rsp_data;

endmodule

`default_nettype wire

// File: verilog/lsq_top.sv
/*
 * Top level of the store-operand path.
 * Connects the queue, read-request stage, register file and capture stage.
 */

`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_top (
	input  logic clk,
	input  logic rst,
	input  logic enq,
	input  logic enq_store,
	input  lsq_pkg::aregno_t enq_areg,
	input  lsq_pkg::pregno_t enq_preg,
	input  lsq_pkg::checkpt_ndx_t enq_cndx,
	input  logic wr,
	input  lsq_pkg::pregno_t wr_preg,
	input  lsq_pkg::data_t wr_data,
	output logic full,
	output logic ret_v,
	output logic ret_store,
	output lsq_pkg::aregno_t ret_areg,
	output lsq_pkg::pregno_t ret_preg,
	output lsq_pkg::checkpt_ndx_t ret_cndx,
	output lsq_pkg::data_t ret_data
);

	// Queue state seen by the request and capture stages
	lsq_pkg::lsq_entry_t [1:0] lsq [0:`LSQ_ROWS-1];
	lsq_pkg::lsq_ndx_t lsq_head;

	// Read request toward the register file
	logic rd_v;
	lsq_pkg::pregno_t rd_preg;
	lsq_pkg::lsq_ndx_t rd_id;

	// Tagged register reply
	logic rsp_v;
	lsq_pkg::pregno_t rsp_preg;
	lsq_pkg::lsq_ndx_t rsp_tag;
	lsq_pkg::data_t rsp_data;

	// Entry data write
	logic cap_wr;
	lsq_pkg::lsq_ndx_t cap_ndx;
	lsq_pkg::data_t cap_data;

	// ====================
	// Instances
	// ====================

	lsq_store u_store (
		.clk(clk), .rst(rst),
		.enq(enq), .enq_store(enq_store), .enq_areg(enq_areg),
		.enq_preg(enq_preg), .enq_cndx(enq_cndx),
		.cap_wr(cap_wr), .cap_ndx(cap_ndx), .cap_data(cap_data),
		.lsq(lsq), .lsq_head(lsq_head), .full(full),
		.ret_v(ret_v), .ret_store(ret_store), .ret_areg(ret_areg),
		.ret_preg(ret_preg), .ret_cndx(ret_cndx), .ret_data(ret_data)
	);

	// aReg, cndx and id1 stay inside the stage, visible there in traces
	lsq_reg_read_req u_rd_req (
		.clk(clk), .rst(rst),
		.lsq_head(lsq_head), .lsq(lsq),
		.aReg(), .rd_preg(rd_preg), .cndx(),
		.id(rd_id), .id1(), .rd_v(rd_v)
	);

	prf u_prf (
		.clk(clk), .rst(rst),
		.wr(wr), .wr_preg(wr_preg), .wr_data(wr_data),
		.rd_v(rd_v), .rd_preg(rd_preg), .rd_tag(rd_id),
		.rsp_v(rsp_v), .rsp_preg(rsp_preg), .rsp_tag(rsp_tag), .rsp_data(rsp_data)
	);

	lsq_data_capture u_capture (
		.rsp_v(rsp_v), .rsp_preg(rsp_preg), .rsp_tag(rsp_tag), .rsp_data(rsp_data),
		.lsq(lsq),
		.cap_wr(cap_wr), .cap_ndx(cap_ndx), .cap_data(cap_data)
	);

endmodule

`default_nettype wire

// File: tests/lsq_tb.sv
/*
 * Testbench for the load/store queue store-operand path.
 * Clock, reset, LFSR stimulus, a model queue of expected retirements,
 * typed compare tasks, a cycle timeout and the directed tests.
 */

`timescale 1ns/10ps
`default_nettype none

`include "lsq_settings.svh"

module lsq_tb;

	localparam int ENTRIES = 2 * `LSQ_ROWS;
	localparam logic [31:0] SEED = 32'h466e3361;
	localparam int FILL_LIMIT = 40;

	// Rough length of each test in cycles
	// The timeout is their sum plus a margin
	localparam int RST_CYCLES = 8;
	localparam int T1_CYCLES = 12;
	localparam int T2_CYCLES = ENTRIES + 4 + 10;
	localparam int T3_CYCLES = 8 + 12 + 6 * 4 + 10;
	localparam int T4_CYCLES = 2 * 20;
	localparam int T5_CYCLES = 32 + FILL_LIMIT + FILL_LIMIT * 4 + 10;
	localparam int MARGIN_CYCLES = 100;
	localparam int TIMEOUT_CYCLES = RST_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
		+ T4_CYCLES + T5_CYCLES + MARGIN_CYCLES;

	logic clk;
	logic rst;
	logic enq;
	logic enq_store;
	lsq_pkg::aregno_t enq_areg;
	lsq_pkg::pregno_t enq_preg;
	lsq_pkg::checkpt_ndx_t enq_cndx;
	logic wr;
	lsq_pkg::pregno_t wr_preg;
	lsq_pkg::data_t wr_data;
	logic full;
	logic ret_v;
	logic ret_store;
	lsq_pkg::aregno_t ret_areg;
	lsq_pkg::pregno_t ret_preg;
	lsq_pkg::checkpt_ndx_t ret_cndx;
	lsq_pkg::data_t ret_data;

	// Expected retirements in order, plus the register contents as written
	lsq_pkg::lsq_entry_t exp_q [$];
	lsq_pkg::data_t reg_model [0:`PREGS-1];

	logic [31:0] lfsr_state;
	int errors;
	int checks;
	int errors_at_start;
	int tests_run;
	int tests_failed;
	int cycle_count;

	lsq_top uut (
		.clk(clk), .rst(rst),
		.enq(enq), .enq_store(enq_store), .enq_areg(enq_areg),
		.enq_preg(enq_preg), .enq_cndx(enq_cndx),
		.wr(wr), .wr_preg(wr_preg), .wr_data(wr_data),
		.full(full),
		.ret_v(ret_v), .ret_store(ret_store), .ret_areg(ret_areg),
		.ret_preg(ret_preg), .ret_cndx(ret_cndx), .ret_data(ret_data)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ====================
	// Stimulus helpers
	// ====================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r[i] = lfsr_state[0];
		end
		return r;
	endfunction

	// Sets the enqueue inputs for the coming edge and records the expected retirement
	task automatic drive_enq(input logic st, input lsq_pkg::pregno_t preg);
		lsq_pkg::lsq_entry_t e;
		e = '0;
		e.v = 1'b1;
		e.store = st;
		e.aRc = lsq_pkg::aregno_t'(rand_bits($bits(lsq_pkg::aregno_t)));
		e.pRc = preg;
		e.cndx = lsq_pkg::checkpt_ndx_t'(rand_bits($bits(lsq_pkg::checkpt_ndx_t)));
		enq = 1'b1;
		enq_store = st;
		enq_areg = e.aRc;
		enq_preg = preg;
		enq_cndx = e.cndx;
		exp_q.push_back(e);
	endtask

	// Single enqueue that is held back while the queue is full
	task automatic enq_one(input logic st, input lsq_pkg::pregno_t preg);
		while (full)
			@(negedge clk);
		drive_enq(st, preg);
		@(negedge clk);
		enq = 1'b0;
	endtask

	task automatic drive_wr(input lsq_pkg::pregno_t preg, input lsq_pkg::data_t d);
		wr = 1'b1;
		wr_preg = preg;
		wr_data = d;
		reg_model[preg] = d;
	endtask

	task automatic write_reg(input lsq_pkg::pregno_t preg, input lsq_pkg::data_t d);
		drive_wr(preg, d);
		@(negedge clk);
		wr = 1'b0;
	endtask

	// Waits until every expected retirement has been seen, then idles a little
	// The idle cycles also catch any retirement nobody asked for
	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
	endtask

	// ====================
	// Compare tasks
	// ====================

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_areg(input string name, input lsq_pkg::aregno_t got,
			input lsq_pkg::aregno_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_preg(input string name, input lsq_pkg::pregno_t got,
			input lsq_pkg::pregno_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_cndx(input string name, input lsq_pkg::checkpt_ndx_t got,
			input lsq_pkg::checkpt_ndx_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input lsq_pkg::data_t got,
			input lsq_pkg::data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// ====================
	// Retirement monitor and timeout
	// ====================

	// Outputs change on the rising edge, so they are read on the falling one
	always @(negedge clk) begin
		lsq_pkg::lsq_entry_t e;
		lsq_pkg::data_t exp_data;
		if (!rst && ret_v) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Unexpected retirement at t=%0t with no entry outstanding", $time);
			end
			else begin
				e = exp_q.pop_front();
				// A store carries what its register held, a load carries zero
				exp_data = e.store ? reg_model[e.pRc] : '0;
				check_bit("ret_store", ret_store, e.store);
				check_areg("ret_areg", ret_areg, e.aRc);
				check_preg("ret_preg", ret_preg, e.pRc);
				check_cndx("ret_cndx", ret_cndx, e.cndx);
				check_data("ret_data", ret_data, exp_data);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ====================
	// Directed tests
	// ====================

	// With nothing enqueued nothing may retire and the queue is not full
	task automatic reset_state();
		repeat (10) begin
			check_bit("ret_v", ret_v, 1'b0);
			check_bit("full", full, 1'b0);
			@(negedge clk);
		end
	endtask

	// More loads than entries, so the pointers wrap past the last row
	task automatic loads_only();
		for (int i = 0; i < ENTRIES + 4; i++)
			enq_one(1'b0, lsq_pkg::pregno_t'(rand_bits($bits(lsq_pkg::pregno_t))));
		wait_drain();
	endtask

	// Registers written first, then stores and loads mixed
	task automatic stores_with_data();
		logic [11:0] mix;
		int s;
		mix = 12'b1011_0010_1001;
		for (int i = 0; i < 8; i++)
			write_reg(lsq_pkg::pregno_t'(1 + i), lsq_pkg::data_t'(rand_bits(`DATA_W)));
		s = 0;
		for (int i = 0; i < 12; i++) begin
			if (mix[i]) begin
				enq_one(1'b1, lsq_pkg::pregno_t'(1 + s));
				s++;
			end
			else begin
				enq_one(1'b0, lsq_pkg::pregno_t'(rand_bits($bits(lsq_pkg::pregno_t))));
			end
		end
		wait_drain();
	endtask

	// Store enters an empty queue and is head at once with two loads queued behind it
	// Its register changes after that, on the request edge (1) or on the read edge (2)
	task automatic late_case(input int wr_at);
		lsq_pkg::pregno_t p;
		lsq_pkg::data_t late_val;
		p = lsq_pkg::pregno_t'(10 + wr_at);
		write_reg(p, lsq_pkg::data_t'(rand_bits(`DATA_W)));
		late_val = lsq_pkg::data_t'(rand_bits(`DATA_W));
		drive_enq(1'b1, p);
		@(negedge clk);
		if (wr_at == 1)
			drive_wr(p, late_val);
		drive_enq(1'b0, lsq_pkg::pregno_t'(rand_bits($bits(lsq_pkg::pregno_t))));
		@(negedge clk);
		wr = 1'b0;
		// Same-edge write and read goes through the register file bypass
		if (wr_at == 2)
			drive_wr(p, late_val);
		drive_enq(1'b0, lsq_pkg::pregno_t'(rand_bits($bits(lsq_pkg::pregno_t))));
		@(negedge clk);
		wr = 1'b0;
		enq = 1'b0;
		// Read and capture edges pass with the loads held behind the store
		repeat (2) begin
			check_bit("ret_v", ret_v, 1'b0);
			@(negedge clk);
		end
		// The store leaves on the fourth edge after it was enqueued
		check_bit("ret_v", ret_v, 1'b1);
		check_bit("ret_store", ret_store, 1'b1);
		@(negedge clk);
		// The first load leaves on the edge after it becomes head
		check_bit("ret_v", ret_v, 1'b1);
		check_bit("ret_store", ret_store, 1'b0);
		wait_drain();
	endtask

	task automatic late_data();
		late_case(1);
		late_case(2);
	endtask

	// Stores only, enqueued faster than they can retire until the queue fills
	task automatic full_queue();
		int n;
		for (int i = 0; i < 32; i++)
			write_reg(lsq_pkg::pregno_t'(32 + i), lsq_pkg::data_t'(rand_bits(`DATA_W)));
		n = 0;
		while (!full && n < FILL_LIMIT) begin
			enq_one(1'b1, lsq_pkg::pregno_t'(32 + n % 32));
			n++;
		end
		check_bit("full", full, 1'b1);
		while (full)
			@(negedge clk);
		// Full drops on the same edge that retires the head store
		check_bit("ret_v", ret_v, 1'b1);
		check_bit("ret_store", ret_store, 1'b1);
		wait_drain();
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %0d %s: passed", tests_run, name);
		end
		else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", tests_run, name,
				errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		rst = 1'b1;
		enq = 1'b0;
		enq_store = 1'b0;
		enq_areg = '0;
		enq_preg = '0;
		enq_cndx = '0;
		wr = 1'b0;
		wr_preg = '0;
		wr_data = '0;
		lfsr_state = SEED;
		errors = 0;
		checks = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		cycle_count = 0;
		// The register file is cleared by reset
		for (int i = 0; i < `PREGS; i++)
			reg_model[i] = '0;

		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;

		reset_state();
		end_test("reset state");
		loads_only();
		end_test("loads only");
		stores_with_data();
		end_test("stores with data");
		late_data();
		end_test("late data");
		full_queue();
		end_test("full queue");

		$display("%0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/lsq_pkg.sv
verilog/lsq_store.sv
verilog/lsq_reg_read_req.sv
verilog/prf.sv
verilog/lsq_data_capture.sv
verilog/lsq_top.sv
tests/lsq_tb.sv
